// ==== include/switch_params.svh ====
`ifndef SWITCH_PARAMS_SVH
`define SWITCH_PARAMS_SVH

// Output side
`define NUM_PORTS 4
`define NUM_PRIOS 2
`define NUM_QUEUES (`NUM_PORTS * `NUM_PRIOS)

// Shared buffer geometry, one page per packet
`define NUM_PAGES 16
`define PAGE_WORDS 8
`define DATA_W 16

// Free pages left when almost_full rises
`define ALMOST_FULL_PAGES 2

`endif

// ==== verilog/switch_pkg.sv ====
`include "switch_params.svh"

package switch_pkg;

    typedef logic [`DATA_W-1:0] word_t;

    typedef logic [$clog2(`NUM_PAGES)-1:0] page_t;

    typedef logic [$clog2(`PAGE_WORDS)-1:0] word_idx_t;

    // Holds 1 to PAGE_WORDS, so one bit wider than the index
    typedef logic [$clog2(`PAGE_WORDS):0] len_t;

    typedef logic [$clog2(`NUM_PORTS)-1:0] port_t;

    // Port in the upper bits, priority in the lsb
    typedef logic [$clog2(`NUM_QUEUES)-1:0] queue_t;

    typedef enum logic [1:0] {
        RD_SCAN,
        RD_POP,
        RD_STREAM
    } rd_state_t;

endpackage

// ==== verilog/word_counter.sv ====
`timescale 1ns/1ns
`include "switch_params.svh"

module word_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  step,
    input  switch_pkg::len_t      load_len,
    output switch_pkg::word_idx_t index,
    output switch_pkg::len_t      count,
    output logic                  last
);

    switch_pkg::len_t len_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= '0;
            count <= '0;
            len_r <= '0;
        end else if (clear) begin
            index <= '0;
            count <= '0;
            len_r <= load_len;
        end else if (step) begin
            index <= index + 1'b1; // Wraps after a full page
            count <= count + 1'b1;
        end
    end

    // Word at index is the final one of the packet
    assign last = (count + 1'b1 == len_r);

endmodule

// ==== verilog/page_buffer.sv ====
`timescale 1ns/1ns
`include "switch_params.svh"

module page_buffer (
    input  logic                  clk,
    input  logic                  we,
    input  switch_pkg::page_t     waddr_page,
    input  switch_pkg::word_idx_t waddr_word,
    input  switch_pkg::word_t     wdata,
    input  logic                  re,
    input  switch_pkg::page_t     raddr_page,
    input  switch_pkg::word_idx_t raddr_word,
    output switch_pkg::word_t     rdata
);

    // Address is page number above word index
    switch_pkg::word_t mem [`NUM_PAGES * `PAGE_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[{waddr_page, waddr_word}] <= wdata;
        end
        if (re) begin
            rdata <= mem[{raddr_page, raddr_word}];
        end
    end

endmodule

// ==== verilog/free_page_list.sv ====
`timescale 1ns/1ns
`include "switch_params.svh"

module free_page_list (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc,
    input  logic              release_en,
    input  switch_pkg::page_t release_page,
    output switch_pkg::page_t free_page,
    output logic              full,
    output logic              almost_full
);

    localparam int CNT_W = $clog2(`NUM_PAGES + 1);

    switch_pkg::page_t page_fifo [`NUM_PAGES];
    switch_pkg::page_t rd_ptr;
    switch_pkg::page_t wr_ptr;
    logic [CNT_W-1:0]  free_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Every page starts out free
            for (int i = 0; i < `NUM_PAGES; i++) begin
                page_fifo[i] <= switch_pkg::page_t'(i);
            end
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            free_cnt <= CNT_W'(`NUM_PAGES);
        end else begin
            if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (release_en) begin
                page_fifo[wr_ptr] <= release_page;
                wr_ptr            <= wr_ptr + 1'b1;
            end
            case ({alloc, release_en})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt; // Both or neither
            endcase
        end
    end

    assign free_page   = page_fifo[rd_ptr];
    assign full        = (free_cnt == '0);
    assign almost_full = (free_cnt <= CNT_W'(`ALMOST_FULL_PAGES));

endmodule

// ==== verilog/queue_table.sv ====
`timescale 1ns/1ns
`include "switch_params.svh"

module queue_table (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enq,
    input  switch_pkg::queue_t     enq_queue,
    input  switch_pkg::page_t      enq_page,
    input  switch_pkg::len_t       enq_len,
    input  logic                   deq,
    input  switch_pkg::queue_t     deq_queue,
    output logic [`NUM_QUEUES-1:0] queue_nonempty,
    output switch_pkg::page_t      head_page,
    output switch_pkg::len_t       head_len
);

    switch_pkg::page_t head [`NUM_QUEUES];
    switch_pkg::page_t tail [`NUM_QUEUES];

    // Per-page link and packet length
    switch_pkg::page_t next_page [`NUM_PAGES];
    switch_pkg::len_t  page_len  [`NUM_PAGES];

    logic deq_last;
    logic enq_to_empty;

    assign deq_last = deq && (head[deq_queue] == tail[deq_queue]);

    // Queue drained by this cycle's dequeue counts as empty
    assign enq_to_empty = !queue_nonempty[enq_queue]
                          || (deq_last && (deq_queue == enq_queue));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            queue_nonempty <= '0;
        end else begin
            if (deq_last) begin
                queue_nonempty[deq_queue] <= 1'b0;
            end
            if (enq) begin
                queue_nonempty[enq_queue] <= 1'b1; // Wins over a same-queue clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deq && !deq_last) begin
            head[deq_queue] <= next_page[head[deq_queue]];
        end
        if (enq) begin
            page_len[enq_page] <= enq_len;
            tail[enq_queue]    <= enq_page;
            if (enq_to_empty) begin
                head[enq_queue] <= enq_page;
            end else begin
                next_page[tail[enq_queue]] <= enq_page;
            end
        end
    end

    assign head_page = head[deq_queue];
    assign head_len  = page_len[head[deq_queue]];

endmodule

// ==== verilog/write_ctrl.sv ====
`timescale 1ns/1ns
`include "switch_params.svh"

module write_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_sop,
    input  logic                  wr_eop,
    input  logic                  wr_vld,
    input  switch_pkg::word_t     wr_data,
    input  logic                  full,
    input  switch_pkg::page_t     free_page,
    output logic                  alloc,
    output logic                  buf_we,
    output switch_pkg::page_t     buf_waddr_page,
    output switch_pkg::word_idx_t buf_waddr_word,
    output switch_pkg::word_t     buf_wdata,
    output logic                  enq,
    output switch_pkg::queue_t    enq_queue,
    output switch_pkg::page_t     enq_page,
    output switch_pkg::len_t      enq_len
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ACCEPT,
        WR_DISCARD
    } wr_state_t;

    wr_state_t             state;
    switch_pkg::page_t     page_r;
    switch_pkg::queue_t    queue_r;
    logic                  hdr_take;
    logic                  word_take;
    switch_pkg::word_idx_t word_index;
    switch_pkg::len_t      word_count;

    assign hdr_take  = (state == WR_IDLE) && wr_sop;
    assign word_take = (state == WR_ACCEPT) && wr_vld;
    assign alloc     = hdr_take && !full; // Page only when one is free

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= WR_IDLE;
            enq   <= 1'b0;
        end else begin
            enq <= word_take && wr_eop; // One cycle behind the last word
            case (state)
                WR_IDLE: begin
                    if (wr_sop) begin
                        state <= full ? WR_DISCARD : WR_ACCEPT;
                    end
                end
                WR_ACCEPT, WR_DISCARD: begin
                    if (wr_vld && wr_eop) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Header gives port in [1:0], priority in [2]
    always_ff @(posedge clk) begin
        if (alloc) begin
            page_r  <= free_page;
            queue_r <= switch_pkg::queue_t'({wr_data[1:0], wr_data[2]});
        end
    end

    word_counter u_word_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (hdr_take),
        .step     (word_take),
        .load_len (switch_pkg::len_t'(`PAGE_WORDS)),
        .index    (word_index),
        .count    (word_count),
        .last     ()
    );

    assign buf_we         = word_take;
    assign buf_waddr_page = page_r;
    assign buf_waddr_word = word_index;
    assign buf_wdata      = wr_data;

    assign enq_queue = queue_r;
    assign enq_page  = page_r;
    assign enq_len   = word_count; // Already holds the final step when enq fires

endmodule

// ==== verilog/read_fsm.sv ====
`timescale 1ns/1ns
`include "switch_params.svh"

module read_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`NUM_PORTS-1:0]  ready,
    input  logic [`NUM_QUEUES-1:0] queue_nonempty,
    input  switch_pkg::page_t      head_page,
    input  switch_pkg::len_t       head_len,
    output logic                   deq,
    output switch_pkg::queue_t     deq_queue,
    output logic                   buf_re,
    output switch_pkg::page_t      buf_raddr_page,
    output switch_pkg::word_idx_t  buf_raddr_word,
    input  switch_pkg::word_t      buf_rdata,
    output logic                   release_en,
    output switch_pkg::page_t      release_page,
    output logic [`NUM_PORTS-1:0]  rd_sop,
    output logic [`NUM_PORTS-1:0]  rd_eop,
    output logic [`NUM_PORTS-1:0]  rd_vld,
    output switch_pkg::word_t      rd_data
);

    switch_pkg::rd_state_t state;
    switch_pkg::port_t     slot;
    switch_pkg::port_t     port_r;
    switch_pkg::queue_t    sel_queue;
    switch_pkg::page_t     page_r;
    switch_pkg::queue_t    hi_queue;
    switch_pkg::queue_t    lo_queue;
    switch_pkg::queue_t    pick_queue;
    logic                  pick;
    logic                  word_last;
    logic                  sop_d;
    logic                  eop_d;
    logic                  vld_d;
    logic [`NUM_PORTS-1:0] port_sel;

    assign lo_queue   = switch_pkg::queue_t'(slot * `NUM_PRIOS);
    assign hi_queue   = switch_pkg::queue_t'(slot * `NUM_PRIOS + 1);
    assign pick_queue = queue_nonempty[hi_queue] ? hi_queue : lo_queue; // Strict priority

    assign pick = (state == switch_pkg::RD_SCAN) && ready[slot]
                  && (queue_nonempty[hi_queue] || queue_nonempty[lo_queue]);

    // Counter loads head_len of the picked queue, so steer the head lookup
    assign deq_queue = (state == switch_pkg::RD_SCAN) ? pick_queue : sel_queue;
    assign deq       = (state == switch_pkg::RD_POP);

    // Reads stop once the last word is in flight
    assign buf_re         = deq || ((state == switch_pkg::RD_STREAM) && !eop_d);
    assign buf_raddr_page = deq ? head_page : page_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= switch_pkg::RD_SCAN;
            slot      <= '0;
            port_r    <= '0;
            sel_queue <= '0;
            sop_d     <= 1'b0;
            eop_d     <= 1'b0;
            vld_d     <= 1'b0;
        end else begin
            sop_d <= deq; // First read goes out in RD_POP
            eop_d <= buf_re && word_last;
            vld_d <= buf_re;
            case (state)
                switch_pkg::RD_SCAN: begin
                    slot <= slot + 1'b1;
                    if (pick) begin
                        port_r    <= slot;
                        sel_queue <= pick_queue;
                        state     <= switch_pkg::RD_POP;
                    end
                end
                switch_pkg::RD_POP: begin
                    state <= switch_pkg::RD_STREAM;
                end
                switch_pkg::RD_STREAM: begin
                    if (eop_d) begin
                        state <= switch_pkg::RD_SCAN;
                    end
                end
                default: state <= switch_pkg::RD_SCAN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            page_r <= head_page;
        end
    end

    word_counter u_word_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (pick),
        .step     (buf_re),
        .load_len (head_len),
        .index    (buf_raddr_word),
        .count    (),
        .last     (word_last)
    );

    assign release_en   = (state == switch_pkg::RD_STREAM) && eop_d;
    assign release_page = page_r;

    assign port_sel = `NUM_PORTS'(1) << port_r;
    assign rd_sop   = sop_d ? port_sel : '0;
    assign rd_eop   = eop_d ? port_sel : '0;
    assign rd_vld   = vld_d ? port_sel : '0;
    assign rd_data  = buf_rdata; // Shared across ports

endmodule

// ==== verilog/packet_switch.sv ====
`timescale 1ns/1ns
`include "switch_params.svh"

module packet_switch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_sop,
    input  logic                  wr_eop,
    input  logic                  wr_vld,
    input  switch_pkg::word_t     wr_data,
    input  logic [`NUM_PORTS-1:0] ready,
    output logic                  full,
    output logic                  almost_full,
    output logic [`NUM_PORTS-1:0] rd_sop,
    output logic [`NUM_PORTS-1:0] rd_eop,
    output logic [`NUM_PORTS-1:0] rd_vld,
    output switch_pkg::word_t     rd_data
);

    logic                   alloc;
    switch_pkg::page_t      free_page;
    logic                   buf_we;
    switch_pkg::page_t      buf_waddr_page;
    switch_pkg::word_idx_t  buf_waddr_word;
    switch_pkg::word_t      buf_wdata;
    logic                   enq;
    switch_pkg::queue_t     enq_queue;
    switch_pkg::page_t      enq_page;
    switch_pkg::len_t       enq_len;
    logic                   deq;
    switch_pkg::queue_t     deq_queue;
    logic [`NUM_QUEUES-1:0] queue_nonempty;
    switch_pkg::page_t      head_page;
    switch_pkg::len_t       head_len;
    logic                   buf_re;
    switch_pkg::page_t      buf_raddr_page;
    switch_pkg::word_idx_t  buf_raddr_word;
    switch_pkg::word_t      buf_rdata;
    logic                   release_en;
    switch_pkg::page_t      release_page;

    write_ctrl u_write_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_sop         (wr_sop),
        .wr_eop         (wr_eop),
        .wr_vld         (wr_vld),
        .wr_data        (wr_data),
        .full           (full),
        .free_page      (free_page),
        .alloc          (alloc),
        .buf_we         (buf_we),
        .buf_waddr_page (buf_waddr_page),
        .buf_waddr_word (buf_waddr_word),
        .buf_wdata      (buf_wdata),
        .enq            (enq),
        .enq_queue      (enq_queue),
        .enq_page       (enq_page),
        .enq_len        (enq_len)
    );

    free_page_list u_free_page_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .release_en   (release_en),
        .release_page (release_page),
        .free_page    (free_page),
        .full         (full),
        .almost_full  (almost_full)
    );

    page_buffer u_page_buffer (
        .clk        (clk),
        .we         (buf_we),
        .waddr_page (buf_waddr_page),
        .waddr_word (buf_waddr_word),
        .wdata      (buf_wdata),
        .re         (buf_re),
        .raddr_page (buf_raddr_page),
        .raddr_word (buf_raddr_word),
        .rdata      (buf_rdata)
    );

    queue_table u_queue_table (
        .clk            (clk),
        .rst_n          (rst_n),
        .enq            (enq),
        .enq_queue      (enq_queue),
        .enq_page       (enq_page),
        .enq_len        (enq_len),
        .deq            (deq),
        .deq_queue      (deq_queue),
        .queue_nonempty (queue_nonempty),
        .head_page      (head_page),
        .head_len       (head_len)
    );

    read_fsm u_read_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .ready          (ready),
        .queue_nonempty (queue_nonempty),
        .head_page      (head_page),
        .head_len       (head_len),
        .deq            (deq),
        .deq_queue      (deq_queue),
        .buf_re         (buf_re),
        .buf_raddr_page (buf_raddr_page),
        .buf_raddr_word (buf_raddr_word),
        .buf_rdata      (buf_rdata),
        .release_en     (release_en),
        .release_page   (release_page),
        .rd_sop         (rd_sop),
        .rd_eop         (rd_eop),
        .rd_vld         (rd_vld),
        .rd_data        (rd_data)
    );

endmodule

// ==== test/tb_packet_switch.sv ====
`timescale 1ns/1ns
`include "switch_params.svh"

module tb_packet_switch;

    logic                  clk;
    logic                  rst_n;
    logic                  wr_sop;
    logic                  wr_eop;
    logic                  wr_vld;
    switch_pkg::word_t     wr_data;
    logic [`NUM_PORTS-1:0] ready;
    logic                  full;
    logic                  almost_full;
    logic [`NUM_PORTS-1:0] rd_sop;
    logic [`NUM_PORTS-1:0] rd_eop;
    logic [`NUM_PORTS-1:0] rd_vld;
    switch_pkg::word_t     rd_data;

    // Expected packets per output port, oldest first
    int                exp_len   [`NUM_PORTS][$];
    switch_pkg::word_t exp_words [`NUM_PORTS][$];

    switch_pkg::word_t got_q [$]; // Words of the packet now streaming
    switch_pkg::word_t pkt_q [$]; // Words of the packet to send

    int seq_errors   = 0;
    int mon_errors   = 0;
    int test_base    = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    packet_switch u_packet_switch (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .ready       (ready),
        .full        (full),
        .almost_full (almost_full),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data)
    );

    always #50 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, inout int count);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            count++;
        end
    endtask

    task automatic report_bad_command(input string cmd);
        $display("Stimulus command %s has missing or malformed fields", cmd);
        seq_errors++;
    endtask

    function automatic int pending();
        int total;
        total = 0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            total += exp_len[p].size();
        end
        return total;
    endfunction

    task automatic read_words(input int fd, input int n);
        int rc;
        int v;
        pkt_q.delete();
        for (int i = 0; i < n; i++) begin
            rc = $fscanf(fd, "%h", v);
            if (rc != 1) begin
                $display("Stimulus word list is shorter than its word count");
                seq_errors++;
            end
            pkt_q.push_back(switch_pkg::word_t'(v));
        end
    endtask

    task automatic expect_packet(input int port);
        exp_len[port].push_back(pkt_q.size());
        foreach (pkt_q[i]) begin
            exp_words[port].push_back(pkt_q[i]);
        end
    endtask

    // Header cycle, then one word per cycle with eop on the last
    task automatic send_packet(input int dest, input int prio);
        @(negedge clk);
        wr_sop  = 1'b1;
        wr_data = switch_pkg::word_t'({prio[0], dest[1:0]});
        foreach (pkt_q[i]) begin
            @(negedge clk);
            wr_sop  = 1'b0;
            wr_vld  = 1'b1;
            wr_data = pkt_q[i];
            wr_eop  = (i == pkt_q.size() - 1);
        end
        @(negedge clk);
        wr_sop  = 1'b0;
        wr_vld  = 1'b0;
        wr_eop  = 1'b0;
        wr_data = '0;
    endtask

    task automatic check_flags(input int exp_full, input int exp_almost);
        repeat (2) @(negedge clk); // Flags trail alloc by a cycle
        compare_value("full", 32'(full), 32'(exp_full), seq_errors);
        compare_value("almost_full", 32'(almost_full), 32'(exp_almost), seq_errors);
    endtask

    task automatic match_packet(input int port);
        int                n;
        switch_pkg::word_t w;
        if (exp_len[port].size() == 0) begin
            $display("Unexpected packet of %0d words on port %0d", got_q.size(), port);
            mon_errors++;
        end else begin
            n = exp_len[port].pop_front();
            compare_value($sformatf("word count on port %0d", port),
                          32'(got_q.size()), 32'(n), mon_errors);
            for (int i = 0; i < n; i++) begin
                w = exp_words[port].pop_front();
                if (i < got_q.size()) begin
                    compare_value($sformatf("rd_data[%0d] on port %0d", i, port),
                                  32'(got_q[i]), 32'(w), mon_errors);
                end
            end
        end
        got_q.delete();
    endtask

    task automatic finish_test(input string name);
        int wait_cycles;
        wait_cycles = 0;
        while ((pending() != 0 || got_q.size() != 0) && wait_cycles < 2000) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (pending() != 0 || got_q.size() != 0) begin
            $display("Timeout in test %s: %0d expected packets never arrived", name, pending());
            seq_errors++;
            for (int p = 0; p < `NUM_PORTS; p++) begin
                exp_len[p].delete();
                exp_words[p].delete();
            end
            got_q.delete();
        end
        repeat (30) @(posedge clk); // Room for a stray packet
        tests_run++;
        if (seq_errors + mon_errors == test_base) begin
            $display("Test %s passed", name);
        end else begin
            $display("Test %s failed with %0d errors", name, seq_errors + mon_errors - test_base);
            tests_failed++;
        end
        test_base = seq_errors + mon_errors;
    endtask

    // Output monitor, one packet streams at a time
    always @(negedge clk) begin
        if (rst_n) begin
            compare_value("rd_sop without rd_vld", 32'(rd_sop & ~rd_vld), 32'h0, mon_errors);
            compare_value("rd_eop without rd_vld", 32'(rd_eop & ~rd_vld), 32'h0, mon_errors);
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (rd_vld[p]) begin
                    if (rd_sop[p]) begin
                        if (got_q.size() != 0) begin
                            $display("Start of packet on port %0d before the last one ended", p);
                            mon_errors++;
                        end
                        got_q.delete();
                    end else if (got_q.size() == 0) begin
                        $display("Data word on port %0d came without a start of packet", p);
                        mon_errors++;
                    end
                    got_q.push_back(rd_data);
                    if (rd_eop[p]) begin
                        match_packet(p);
                    end
                end
            end
        end
    end

    initial begin
        int    fd;
        int    rc;
        int    a;
        int    b;
        int    n;
        string cmd;
        string line;
        clk     = 1'b0;
        rst_n   = 1'b0;
        wr_sop  = 1'b0;
        wr_eop  = 1'b0;
        wr_vld  = 1'b0;
        wr_data = '0;
        ready   = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("test/switch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/switch_stimulus.txt");
            seq_errors++;
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    void'($fgets(line, fd));
                end else if (cmd == "S" || cmd == "X") begin
                    rc = $fscanf(fd, "%d %d %d", a, b, n);
                    if (rc != 3) begin
                        report_bad_command(cmd);
                    end
                    read_words(fd, n);
                    if (cmd == "X") begin
                        expect_packet(a); // Same words back on the destination
                    end
                    send_packet(a, b);
                end else if (cmd == "E") begin
                    rc = $fscanf(fd, "%d %d", a, n);
                    if (rc != 2) begin
                        report_bad_command(cmd);
                    end
                    read_words(fd, n);
                    expect_packet(a);
                end else if (cmd == "R") begin
                    rc = $fscanf(fd, "%h", a);
                    if (rc != 1) begin
                        report_bad_command(cmd);
                    end
                    @(negedge clk);
                    ready = a[`NUM_PORTS-1:0];
                end else if (cmd == "F") begin
                    rc = $fscanf(fd, "%d %d", a, b);
                    if (rc != 2) begin
                        report_bad_command(cmd);
                    end
                    check_flags(a, b);
                end else if (cmd == "P") begin
                    rc = $fscanf(fd, "%s", line);
                    if (rc != 1) begin
                        report_bad_command(cmd);
                    end
                    finish_test(line);
                end else begin
                    $display("Unknown stimulus command %s", cmd);
                    seq_errors++;
                end
            end
            $fclose(fd);
        end
        if (tests_run == 0) begin
            $display("No test ran from the stimulus file");
            seq_errors++;
        end

        $display("%0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, seq_errors + mon_errors);
        if (seq_errors + mon_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== test/switch_stimulus.txt ====
# S dest prio n words = send | X dest prio n words = send, expect on dest | E port n words
# R ready_mask | F full almost_full | P test_name ends a test; all numbers in words are hex
R f
X 0 0 1 1001
X 1 1 8 1100 1101 1102 1103 1104 1105 1106 1107
X 2 0 8 1200 1201 1202 1203 1204 1205 1206 1207
X 3 1 1 1301
P single_packets
R d
S 1 0 2 2000 2001
S 1 1 3 2100 2101 2102
E 1 3 2100 2101 2102
E 1 2 2000 2001
R f
P priority_order
R 0
X 2 1 3 3000 3001 3002
X 2 1 1 3100
X 2 1 4 3200 3201 3202 3203
R f
P queue_order
R 0
X 0 0 1 4000
X 1 1 2 4010 4011
X 2 0 1 4020
X 3 1 2 4030 4031
X 0 0 2 4040 4041
X 1 1 1 4050
X 2 0 2 4060 4061
X 3 1 1 4070
X 0 0 1 4080
X 1 1 2 4090 4091
X 2 0 1 40a0
X 3 1 2 40b0 40b1
X 0 0 2 40c0 40c1
F 0 0
X 1 1 1 40d0
F 0 1
X 2 0 2 40e0 40e1
X 3 1 8 40f0 40f1 40f2 40f3 40f4 40f5 40f6 40f7
F 1 1
S 0 0 2 dead beef
F 1 1
R f
P full_drop
F 0 0
X 0 1 2 5000 5001
X 3 0 8 5300 5301 5302 5303 5304 5305 5306 5307
X 2 1 1 5200
P page_reuse
R a
X 0 1 2 6000 6001
X 1 0 3 6100 6101 6102
X 2 1 1 6200
X 3 0 2 6300 6301
X 0 1 1 6010
X 1 0 1 6110
X 2 1 4 6210 6211 6212 6213
X 3 0 1 6310
R f
P multi_port

// ==== packet_switch.f ====
+incdir+include
verilog/switch_pkg.sv
verilog/word_counter.sv
verilog/page_buffer.sv
verilog/free_page_list.sv
verilog/queue_table.sv
verilog/write_ctrl.sv
verilog/read_fsm.sv
verilog/packet_switch.sv
test/tb_packet_switch.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module tb_packet_switch \
    -f packet_switch.f -Mdir obj_dir -o sim_packet_switch

./obj_dir/sim_packet_switch > sim.log
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"
